/* compile.f */
+incdir+common
common/ooo_pkg.sv
rename/rename_map.sv
rename/free_list.sv
src/prf.sv
src/rs.sv
src/alu.sv
rob/rob.sv
src/processor.sv
tests/processor_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module processor_tb &&
./obj_dir/Vprocessor_tb | tee /dev/stderr | grep -q '>>> PASS' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* tests/processor_tb.sv */
// testbench for the rename core with clock, reset, stimulus, reference model and commit checks
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module processor_tb
	import ooo_pkg::*;
();

	localparam int CLK_PERIOD  = 40;
	localparam int NUM_OPS     = 12 + 16 + 200 + 32 + 6;   // ops over all tests
	localparam int CYCLE_LIMIT = 40 * NUM_OPS + 200;

	typedef logic [`ARF_SIZE-1:0][`DATA_WIDTH-1:0] arch_file_t;   // architectural state model

	logic          clock;
	logic          arst_n;
	logic          dispatch_valid;
	dispatch_op_t  dispatch;
	logic          stall;
	logic          commit_valid;
	commit_t       commit;

	arch_file_t  arch_model;
	commit_t     exp_q [$];        // expected commits in dispatch order
	int          errors = 0;
	int          accepted = 0;
	int          commits = 0;
	int          cycles = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_err_start = 0;
	logic        saw_stall = 1'b0;

	processor DUT (.clock(clock), .arst_n(arst_n), .dispatch_valid(dispatch_valid),
		.dispatch(dispatch), .stall(stall), .commit_valid(commit_valid), .commit(commit));

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////
	// reference model
	function automatic commit_t ref_execute(input dispatch_op_t op, inout arch_file_t regs);
		data_t    a;
		data_t    b;
		data_t    r;
		commit_t  c;
		a = (op.arn_opa == arn_t'(`ZERO_REG)) ? '0 : regs[op.arn_opa];   // r31 reads 0
		b = (op.arn_opb == arn_t'(`ZERO_REG)) ? '0 : regs[op.arn_opb];
		if (op.opb_is_imm) begin
			b = data_t'(op.imm);   // zero extended
		end
		case (op.alu_func)
			ALU_ADD: r = a + b;
			ALU_SUB: r = a - b;
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_XOR: r = a ^ b;
			ALU_SLL: r = a << b[5:0];
			default: r = '0;
		endcase
		c.arn_dest = op.arn_dest;
		c.wr_en    = op.arn_dest != arn_t'(`ZERO_REG);
		c.value    = c.wr_en ? r : '0;   // no-dest commits report 0
		if (c.wr_en) begin
			regs[op.arn_dest] = r;
		end
		return c;
	endfunction

	function automatic dispatch_op_t make_op(input alu_func_t f, input int dest, input int src_a,
		input int src_b, input logic use_imm, input logic [15:0] imm);
		dispatch_op_t op;
		op.alu_func   = f;
		op.arn_dest   = arn_t'(dest);
		op.arn_opa    = arn_t'(src_a);
		op.arn_opb    = arn_t'(src_b);
		op.opb_is_imm = use_imm;
		op.imm        = imm;
		return op;
	endfunction

	function automatic int pick_reg();
		int r;
		r = $urandom_range(0, 7);
		return (r == 7) ? `ZERO_REG : r % 5;   // few regs, lots of hazards
	endfunction

	////////////////////
	// checks
	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_commit(input commit_t got, input commit_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error: commit got arn_dest=%h wr_en=%h value=%h, expected %h %h %h",
				got.arn_dest, got.wr_en, got.value, exp.arn_dest, exp.wr_en, exp.value);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_err_start) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - test_err_start);
		end else begin
			$display("test %s: passed", name);
		end
		test_err_start = errors;
	endtask

	// compare each commit against the oldest expected one
	initial begin : compare_commits
		commit_t exp;
		forever begin
			@(negedge clock);   // commit outputs settle well before this
			if (arst_n && commit_valid) begin
				commits++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("a commit arrived with no operation pending");
				end else begin
					exp = exp_q.pop_front();
					check_commit(commit, exp);
				end
			end
		end
	end

	initial begin : watchdog
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display(">>> FAIL");
		$finish;
	end

	////////////////////
	// stimulus
	task automatic send_op(input dispatch_op_t op);
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clock);
			dispatch_valid = 1'b1;   // held until accepted
			dispatch       = op;
			#(CLK_PERIOD / 4);       // stall settles after the drive
			if (stall) begin
				saw_stall = 1'b1;
			end else begin
				taken = 1'b1;
				exp_q.push_back(ref_execute(op, arch_model));
				accepted++;
			end
			@(posedge clock);
		end
	endtask

	task automatic drain();
		@(negedge clock);
		dispatch_valid = 1'b0;
		while (exp_q.size() != 0) @(posedge clock);
		repeat (2) @(posedge clock);   // room for a stray commit
	endtask

	task automatic independent_ops();
		for (int i = 0; i < 12; i++) begin
			send_op(make_op(alu_func_t'(3'(i % 6)), i + 1, (i < 6) ? 20 : i - 5, 21,
				i % 4 != 3, 16'(16'h1234 + i * 16'h0111)));
		end
		drain();
	endtask

	task automatic dependent_chains();
		send_op(make_op(ALU_ADD, 5, `ZERO_REG, `ZERO_REG, 1'b1, 16'h0003));   // chain seed
		for (int i = 1; i < 16; i++) begin
			send_op(make_op(alu_func_t'(3'(i % 6)), 5 + i % 2, 5 + (i - 1) % 2, 1,
				i % 3 != 0, 16'(i * 7 + 1)));   // reads the previous dest
		end
		drain();
	endtask

	task automatic random_program();
		for (int i = 0; i < 200; i++) begin
			send_op(make_op(alu_func_t'(3'($urandom_range(0, 5))), pick_reg(), pick_reg(),
				pick_reg(), 1'($urandom_range(0, 1)), 16'($urandom)));
		end
		drain();
	endtask

	task automatic stall_burst();
		saw_stall = 1'b0;
		send_op(make_op(ALU_ADD, 9, `ZERO_REG, `ZERO_REG, 1'b1, 16'h0001));
		for (int i = 1; i < 8; i++) begin
			send_op(make_op(ALU_ADD, 9, 9, 9, 1'b0, 16'h0000));   // doubling chain on r9
		end
		for (int i = 0; i < 24; i++) begin
			send_op(make_op(alu_func_t'(3'(i % 6)), (i % 6 == 5) ? `ZERO_REG : 10 + i % 8, 9, 9,
				i % 2 == 0, 16'(i + 1)));   // all wait on the chain end
		end
		drain();
		if (!saw_stall) begin
			errors++;
			$display("stall never rose during the burst");
		end
	endtask

	task automatic zero_reg_ops();
		send_op(make_op(ALU_ADD, `ZERO_REG, 1, 2, 1'b0, 16'h0000));   // result dropped
		send_op(make_op(ALU_XOR, `ZERO_REG, 3, 3, 1'b1, 16'h5a5a));
		send_op(make_op(ALU_ADD, 7, `ZERO_REG, `ZERO_REG, 1'b0, 16'h0000));
		send_op(make_op(ALU_OR, 8, `ZERO_REG, `ZERO_REG, 1'b1, 16'h00ff));
		send_op(make_op(ALU_SUB, 7, 8, `ZERO_REG, 1'b0, 16'h0000));
		send_op(make_op(ALU_ADD, `ZERO_REG, `ZERO_REG, `ZERO_REG, 1'b1, 16'hffff));
		drain();
	endtask

	initial begin : main
		void'($urandom(32'hd78bc71b));   // single seed for the run
		arst_n         = 1'b0;
		dispatch_valid = 1'b0;
		dispatch       = '0;
		arch_model     = '0;
		repeat (4) begin
			@(negedge clock);
			check_bit("commit_valid", commit_valid, 1'b0);
			check_bit("stall", stall, 1'b0);
		end
		arst_n = 1'b1;   // released on a falling edge
		@(negedge clock);
		check_bit("commit_valid", commit_valid, 1'b0);
		check_bit("stall", stall, 1'b0);
		end_test("reset");
		independent_ops();
		end_test("independent ops");
		dependent_chains();
		end_test("dependent chains");
		random_program();
		end_test("random program");
		stall_burst();
		end_test("stall burst");
		zero_reg_ops();
		end_test("zero register");
		if (commits != accepted) begin
			errors++;
			$display("%0d commits seen but %0d operations accepted", commits, accepted);
		end
		$display("summary: %0d tests, %0d failed, %0d errors, %0d ops, %0d commits",
			tests_run, tests_failed, errors, accepted, commits);
		if (errors == 0 && tests_failed == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* src/processor.sv */
// top of the rename core, dispatch through retirement
`timescale 1ns/1ns

module processor
	import ooo_pkg::*;
(
	input  logic          clock,
	input  logic          arst_n,
	input  logic          dispatch_valid,
	input  dispatch_op_t  dispatch,
	output logic          stall,          // only back-pressure
	output logic          commit_valid,
	output commit_t       commit
);

	logic         accept;
	logic         has_dest;
	prn_t         prn_opa;
	prn_t         prn_opb;
	prn_t         prn_old;
	prn_t         prn_dest;
	prn_t         alloc_prn;
	logic         fl_empty;
	data_t        val_opa;
	data_t        val_opb;
	logic         rdy_opa;
	logic         rdy_opb;
	renamed_op_t  rs_entry;
	logic         rs_full;
	logic         issue_valid;
	renamed_op_t  issue;
	cdb_t         cdb;
	rob_idx_t     rob_tail;
	logic         rob_full;
	prn_t         head_prn;
	data_t        head_value;
	logic         retire_en;
	prn_t         release_prn;

	assign stall  = rob_full | rs_full | (fl_empty & has_dest);
	assign accept = dispatch_valid & ~stall;

	// no dest keeps the zero reg's own prn as tag
	assign prn_dest = has_dest ? alloc_prn : prn_old;

	////////////////////
	// rename
	rename_map u_rename_map (.clock(clock), .arst_n(arst_n), .rename_en(accept),
		.op(dispatch), .new_prn(alloc_prn), .prn_opa(prn_opa), .prn_opb(prn_opb),
		.prn_old(prn_old), .has_dest(has_dest));

	free_list u_free_list (.clock(clock), .arst_n(arst_n), .alloc(accept & has_dest),
		.alloc_prn(alloc_prn), .empty(fl_empty), .release_en(retire_en),
		.release_prn(release_prn));

	// zero-reg sources map to the pinned prn and read 0, ready
	prf u_prf (.clock(clock), .arst_n(arst_n), .rd_opa(prn_opa), .rd_opb(prn_opb),
		.rd_commit(head_prn), .val_opa(val_opa), .val_opb(val_opb),
		.val_commit(head_value), .rdy_opa(rdy_opa), .rdy_opb(rdy_opb),
		.alloc_en(accept & has_dest), .alloc_prn(alloc_prn), .cdb(cdb));

	always_comb begin
		rs_entry.alu_func  = dispatch.alu_func;
		rs_entry.has_dest  = has_dest;
		rs_entry.prn_dest  = prn_dest;
		rs_entry.prn_old   = prn_old;
		rs_entry.rob_idx   = rob_tail;
		rs_entry.opa_value = val_opa;
		rs_entry.opa_ready = rdy_opa;
		rs_entry.opa_tag   = prn_opa;
		rs_entry.opb_value = dispatch.opb_is_imm ? data_t'(dispatch.imm) : val_opb;
		rs_entry.opb_ready = dispatch.opb_is_imm | rdy_opb;   // imm never waits
		rs_entry.opb_tag   = prn_opb;
	end

	////////////////////
	// issue and execute
	rs u_rs (.clock(clock), .arst_n(arst_n), .load(accept), .entry(rs_entry), .cdb(cdb),
		.full(rs_full), .issue_valid(issue_valid), .issue(issue));

	alu u_alu (.clock(clock), .arst_n(arst_n), .issue_valid(issue_valid), .issue(issue),
		.cdb(cdb));

	////////////////////
	// in-order retirement
	rob u_rob (.clock(clock), .arst_n(arst_n), .alloc(accept), .has_dest(has_dest),
		.arn_dest(dispatch.arn_dest), .prn_dest(prn_dest), .prn_old(prn_old),
		.tail_idx(rob_tail), .full(rob_full), .cdb(cdb), .head_prn(head_prn),
		.head_value(head_value), .retire_en(retire_en), .release_prn(release_prn),
		.commit_valid(commit_valid), .commit(commit));

endmodule

/* rob/rob.sv */
// circular reorder buffer with in-order single retirement
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module rob
	import ooo_pkg::*;
(
	input  logic      clock,
	input  logic      arst_n,
	input  logic      alloc,          // op accepted at dispatch
	input  logic      has_dest,
	input  arn_t      arn_dest,
	input  prn_t      prn_dest,
	input  prn_t      prn_old,
	output rob_idx_t  tail_idx,       // slot given to the incoming op
	output logic      full,
	input  cdb_t      cdb,
	output prn_t      head_prn,       // to prf for the commit value
	input  data_t     head_value,
	output logic      retire_en,      // free list release
	output prn_t      release_prn,
	output logic      commit_valid,
	output commit_t   commit
);

	typedef logic [$clog2(`ROB_SIZE):0] rob_cnt_t;

	typedef struct packed {
		arn_t  arn_dest;
		logic  has_dest;
		prn_t  prn_dest;
		prn_t  prn_old;
	} rob_entry_t;

	rob_entry_t           entries [`ROB_SIZE];
	logic [`ROB_SIZE-1:0] done;
	rob_idx_t             head;
	rob_idx_t             tail;
	rob_cnt_t             count;
	logic                 head_ok;

	assign full     = count == rob_cnt_t'(`ROB_SIZE);
	assign tail_idx = tail;

	////////////////////
	// retirement side
	assign head_ok      = (count != '0) && done[head];
	assign head_prn     = entries[head].prn_dest;
	assign commit_valid = head_ok;
	assign retire_en    = head_ok && entries[head].has_dest;   // zero-reg ops free nothing
	assign release_prn  = entries[head].prn_old;

	assign commit.arn_dest = entries[head].arn_dest;
	assign commit.wr_en    = entries[head].has_dest;
	assign commit.value    = entries[head].has_dest ? head_value : '0;

	always_ff @(posedge clock) begin
		if (alloc) begin
			entries[tail] <= '{arn_dest: arn_dest, has_dest: has_dest,
				prn_dest: prn_dest, prn_old: prn_old};
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (cdb.valid) begin
				done[cdb.rob_idx] <= 1'b1;   // completion from the bus
			end
			if (alloc) begin
				done[tail] <= 1'b0;   // never the slot being completed
				tail       <= tail + rob_idx_t'(1);
			end
			if (head_ok) begin
				head <= head + rob_idx_t'(1);
			end
			if (alloc && !head_ok) begin
				count <= count + rob_cnt_t'(1);
			end else if (head_ok && !alloc) begin
				count <= count - rob_cnt_t'(1);
			end
		end
	end

	// dispatch stall has to cover a full buffer
	a_no_alloc_full: assert property (@(posedge clock) disable iff (!arst_n)
		alloc |-> !full);

endmodule

/* src/alu.sv */
// single-cycle integer alu, registered onto the result bus
`timescale 1ns/1ns

module alu
	import ooo_pkg::*;
(
	input  logic         clock,
	input  logic         arst_n,
	input  logic         issue_valid,
	input  renamed_op_t  issue,
	output cdb_t         cdb
);

	data_t     result;
	logic      valid_q;
	prn_t      tag_q;
	rob_idx_t  rob_idx_q;
	data_t     value_q;

	// opb already holds the immediate when the op had one
	always_comb begin
		case (issue.alu_func)
			ALU_ADD: result = issue.opa_value + issue.opb_value;
			ALU_SUB: result = issue.opa_value - issue.opb_value;
			ALU_AND: result = issue.opa_value & issue.opb_value;
			ALU_OR:  result = issue.opa_value | issue.opb_value;
			ALU_XOR: result = issue.opa_value ^ issue.opb_value;
			ALU_SLL: result = issue.opa_value << issue.opb_value[5:0];
			default: result = '0;   // unused encodings
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue_valid;   // one result per cycle at most
		end
	end

	always_ff @(posedge clock) begin
		tag_q     <= issue.prn_dest;
		rob_idx_q <= issue.rob_idx;
		value_q   <= result;
	end

	assign cdb.valid   = valid_q;
	assign cdb.tag     = tag_q;
	assign cdb.rob_idx = rob_idx_q;
	assign cdb.value   = value_q;

endmodule

/* src/rs.sv */
// reservation station, compacting queue that issues the oldest ready op
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module rs
	import ooo_pkg::*;
(
	input  logic         clock,
	input  logic         arst_n,
	input  logic         load,         // op accepted at dispatch
	input  renamed_op_t  entry,
	input  cdb_t         cdb,
	output logic         full,
	output logic         issue_valid,
	output renamed_op_t  issue
);

	localparam int RS_IW = $clog2(`RS_SIZE);

	typedef logic [RS_IW-1:0] rs_idx_t;
	typedef logic [RS_IW:0] rs_cnt_t;

	renamed_op_t          entries [`RS_SIZE];   // index 0 is oldest
	renamed_op_t          nxt     [`RS_SIZE];
	rs_cnt_t              count;
	logic [`RS_SIZE-1:0]  ready_vec;
	rs_idx_t              issue_idx;
	rs_idx_t              fill_idx;

	// capture a broadcast for any operand still waiting on its tag
	function automatic renamed_op_t wake(renamed_op_t op, cdb_t bus);
		renamed_op_t w;
		w = op;
		if (bus.valid && !op.opa_ready && (bus.tag == op.opa_tag)) begin
			w.opa_ready = 1'b1;
			w.opa_value = bus.value;
		end
		if (bus.valid && !op.opb_ready && (bus.tag == op.opb_tag)) begin
			w.opb_ready = 1'b1;
			w.opb_value = bus.value;
		end
		return w;
	endfunction

	assign full = count == rs_cnt_t'(`RS_SIZE);

	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			ready_vec[i] = (rs_cnt_t'(i) < count) && entries[i].opa_ready
				&& entries[i].opb_ready;
		end
	end

	// lowest index wins, which is the oldest
	always_comb begin
		issue_idx = '0;
		for (int i = `RS_SIZE - 1; i >= 0; i--) begin
			if (ready_vec[i]) begin
				issue_idx = rs_idx_t'(i);
			end
		end
	end

	assign issue_valid = |ready_vec;
	assign issue       = entries[issue_idx];

	// new op lands behind the survivors
	assign fill_idx = count[RS_IW-1:0] - rs_idx_t'(issue_valid);

	////////////////////
	// next contents, wakeup then close the gap of the issued slot
	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			nxt[i] = wake(entries[i], cdb);
		end
		if (issue_valid) begin
			for (int i = 0; i < `RS_SIZE - 1; i++) begin
				if (rs_idx_t'(i) >= issue_idx) begin
					nxt[i] = wake(entries[i+1], cdb);   // shift down
				end
			end
		end
		if (load) begin
			nxt[fill_idx] = wake(entry, cdb);   // no wakeup lost at entry
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			entries[i] <= nxt[i];
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (load && !issue_valid) begin
			count <= count + rs_cnt_t'(1);
		end else if (!load && issue_valid) begin
			count <= count - rs_cnt_t'(1);
		end
	end

	// an issuing op never reads a tag whose producer is only now on the bus
	a_issue_ready: assert property (@(posedge clock) disable iff (!arst_n)
		(issue_valid && cdb.valid && (cdb.tag != prn_t'(`ZERO_REG)))
		|-> (issue.opa_tag != cdb.tag));

endmodule

/* src/prf.sv */
// physical register values and ready bits with result bus bypass
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module prf
	import ooo_pkg::*;
(
	input  logic   clock,
	input  logic   arst_n,
	input  prn_t   rd_opa,
	input  prn_t   rd_opb,
	input  prn_t   rd_commit,    // head of rob
	output data_t  val_opa,
	output data_t  val_opb,
	output data_t  val_commit,
	output logic   rdy_opa,
	output logic   rdy_opb,
	input  logic   alloc_en,     // new dest, clears ready
	input  prn_t   alloc_prn,
	input  cdb_t   cdb
);

	data_t               values [`PRF_SIZE];
	logic [`PRF_SIZE-1:0] ready;
	logic                cdb_wr;
	logic                hit_opa;
	logic                hit_opb;

	// prn of the zero reg stays pinned at 0, no-dest results land nowhere
	assign cdb_wr = cdb.valid && (cdb.tag != prn_t'(`ZERO_REG));

	assign hit_opa = cdb_wr && (cdb.tag == rd_opa);   // same-cycle broadcast
	assign hit_opb = cdb_wr && (cdb.tag == rd_opb);

	assign rdy_opa    = ready[rd_opa] | hit_opa;
	assign rdy_opb    = ready[rd_opb] | hit_opb;
	assign val_opa    = hit_opa ? cdb.value : values[rd_opa];
	assign val_opb    = hit_opb ? cdb.value : values[rd_opb];
	assign val_commit = values[rd_commit];   // written at least a cycle earlier

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `PRF_SIZE; i++) begin
				values[i] <= '0;   // every arch reg reads 0 after reset
			end
			ready <= '1;
		end else begin
			if (cdb_wr) begin
				values[cdb.tag] <= cdb.value;
				ready[cdb.tag]  <= 1'b1;
			end
			if (alloc_en) begin
				ready[alloc_prn] <= 1'b0;   // producer now in flight
			end
		end
	end

endmodule

/* rename/free_list.sv */
// circular queue of unallocated physical registers
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module free_list
	import ooo_pkg::*;
(
	input  logic  clock,
	input  logic  arst_n,
	input  logic  alloc,         // pop at rename
	output prn_t  alloc_prn,     // head of queue
	output logic  empty,
	input  logic  release_en,    // push at retire
	input  prn_t  release_prn
);

	localparam int FL_DEPTH = `PRF_SIZE - `ARF_SIZE;   // max free prns at any time

	typedef logic [$clog2(FL_DEPTH)-1:0] fl_ptr_t;
	typedef logic [$clog2(FL_DEPTH):0] fl_cnt_t;

	prn_t     queue [FL_DEPTH];
	fl_ptr_t  head;
	fl_ptr_t  tail;
	fl_cnt_t  count;

	assign alloc_prn = queue[head];
	assign empty     = count == '0;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < FL_DEPTH; i++) begin
				queue[i] <= prn_t'(`ARF_SIZE + i);   // upper half starts free
			end
			head  <= '0;
			tail  <= '0;   // wraps to head when full
			count <= fl_cnt_t'(FL_DEPTH);
		end else begin
			if (alloc) begin
				head <= head + fl_ptr_t'(1);
			end
			if (release_en) begin
				queue[tail] <= release_prn;
				tail        <= tail + fl_ptr_t'(1);
			end
			if (alloc && !release_en) begin
				count <= count - fl_cnt_t'(1);
			end else if (release_en && !alloc) begin
				count <= count + fl_cnt_t'(1);
			end
		end
	end

	// dispatch must stall before the pool runs dry
	a_no_alloc_empty: assert property (@(posedge clock) disable iff (!arst_n)
		alloc |-> !empty);

endmodule

/* rename/rename_map.sv */
// speculative map table from architectural to physical registers
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module rename_map
	import ooo_pkg::*;
(
	input  logic          clock,
	input  logic          arst_n,
	input  logic          rename_en,   // op accepted this cycle
	input  dispatch_op_t  op,
	input  prn_t          new_prn,     // from the free list
	output prn_t          prn_opa,
	output prn_t          prn_opb,
	output prn_t          prn_old,     // mapping being replaced, freed at retire
	output logic          has_dest
);

	prn_t map_table [`ARF_SIZE];   // arn -> prn

	// the zero register keeps its identity mapping forever
	assign has_dest = op.arn_dest != arn_t'(`ZERO_REG);

	// lookups see the table before this op's own update
	assign prn_opa = map_table[op.arn_opa];
	assign prn_opb = map_table[op.arn_opb];
	assign prn_old = map_table[op.arn_dest];   // also the zero reg's prn when no dest

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				map_table[i] <= prn_t'(i);   // identity after reset
			end
		end else if (rename_en && has_dest) begin
			map_table[op.arn_dest] <= new_prn;   // visible from next cycle
		end
	end

endmodule

/* common/ooo_pkg.sv */
// index, function and bus types shared across the rename core
`include "ooo_cfg.svh"

package ooo_pkg;

	typedef logic [$clog2(`ARF_SIZE)-1:0] arn_t;      // architectural register index
	typedef logic [$clog2(`PRF_SIZE)-1:0] prn_t;      // physical register index
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;  // reorder buffer slot
	typedef logic [`DATA_WIDTH-1:0] data_t;           // operand / result

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5    // shift by opb[5:0]
	} alu_func_t;

	// decoded op as presented at dispatch
	typedef struct packed {
		alu_func_t              alu_func;
		arn_t                   arn_dest;
		arn_t                   arn_opa;
		arn_t                   arn_opb;
		logic                   opb_is_imm;   // take imm instead of arn_opb
		logic [`IMM_WIDTH-1:0]  imm;          // zero extended
	} dispatch_op_t;

	// op after rename, held in the station
	typedef struct packed {
		alu_func_t  alu_func;
		logic       has_dest;
		prn_t       prn_dest;
		prn_t       prn_old;
		rob_idx_t   rob_idx;
		data_t      opa_value;
		logic       opa_ready;
		prn_t       opa_tag;
		data_t      opb_value;
		logic       opb_ready;
		prn_t       opb_tag;
	} renamed_op_t;

	// result bus, single writer
	typedef struct packed {
		logic      valid;
		prn_t      tag;
		rob_idx_t  rob_idx;
		data_t     value;
	} cdb_t;

	// retirement report
	typedef struct packed {
		arn_t   arn_dest;
		logic   wr_en;
		data_t  value;
	} commit_t;

endpackage

/* common/ooo_cfg.svh */
// sizes of the out-of-order core and its register spaces
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// architectural register file
`define ARF_SIZE 32      // visible registers
`define ZERO_REG 31      // hardwired zero, never renamed

// physical register file
`define PRF_SIZE 64      // renamed registers, half of them free after reset

// window structures
`define ROB_SIZE 16      // in-flight operations
`define RS_SIZE 8        // waiting operations

// datapath
`define DATA_WIDTH 64    // operand and result width
`define IMM_WIDTH 16     // zero-extended immediate field

`endif
